//--- src/tcp_conn_params.svh
// ######################################
// Widths and counts for the TCP connection
// table. Include wherever a port or a type
// needs one of these sizes.
// ######################################

`ifndef TCP_CONN_PARAMS_SVH
`define TCP_CONN_PARAMS_SVH

// Number of vFPGA regions sharing the stack
`define N_REGIONS 4
`define REGION_BITS 2

// Hash slot index
`define HASH_BITS 8

// Key fields and session id
`define IP_ADDR_BITS 32
`define IP_PORT_BITS 16
`define SID_BITS 16

`endif

//--- src/tcp_conn_pkg.sv
// ######################################
// Shared types for the TCP connection table.
// Modules import this package in their body
// and use scoped names in their port lists.
// ######################################

`default_nettype none

`include "tcp_conn_params.svh"

package tcp_conn_pkg;

  typedef logic [`IP_ADDR_BITS-1:0] ip_addr_t;
  typedef logic [`IP_PORT_BITS-1:0] ip_port_t;
  typedef logic [`SID_BITS-1:0]     tcp_sid_t;
  typedef logic [`REGION_BITS-1:0]  region_id_t;
  typedef logic [`HASH_BITS-1:0]    hash_t;

  // Held flag on top, owner region below
  typedef logic [`REGION_BITS:0]    slot_t;

  typedef enum logic [3:0] {
    IDLE,
    REQ_HASH,
    REQ_LUP,
    REQ_CHECK,
    REQ_SEND,
    REQ_COL,
    RSP_HASH,
    RSP_LUP,
    RSP_SEND
  } conn_state_t;

endpackage

`default_nettype wire

//--- src/meta_if.sv
// ######################################
// Valid/ready channel with a data word and
// the id of the region it belongs to.
// Master drives valid, data and id.
// ######################################

`timescale 1ns/1ps
`default_nettype none

interface meta_if #(
  parameter int DATA_BITS = 48
) ();
  import tcp_conn_pkg::*;

  logic                 valid;
  logic                 ready;
  logic [DATA_BITS-1:0] data;
  region_id_t           id;

  modport m (output valid, output data, output id, input ready);
  modport s (input valid, input data, input id, output ready);

endinterface

`default_nettype wire

//--- src/meta_arbiter.sv
// ######################################
// Round-robin arbiter from per-region
// request lanes onto one meta_if master.
// Grant is combinational; the pointer
// moves to the winner on each transfer.
// ######################################

`timescale 1ns/1ps
`default_nettype none

`include "tcp_conn_params.svh"

module meta_arbiter #(
  parameter int DATA_BITS = 48
) (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic [`N_REGIONS-1:0]           req_valid,
  output logic [`N_REGIONS-1:0]           req_ready,
  input  logic [`N_REGIONS*DATA_BITS-1:0] req_data,
  meta_if.m                               m_meta
);
  import tcp_conn_pkg::*;

  region_id_t ptr_q;
  region_id_t grant_id;
  logic       grant_found;

  // First valid lane after the last grant, with wrap-around
  always_comb begin : grant_sel
    int cand;
    grant_found = 1'b0;
    grant_id    = ptr_q;
    for (int i = 1; i <= `N_REGIONS; i++) begin
      cand = (int'(ptr_q) + i) % `N_REGIONS;
      if (!grant_found && req_valid[cand]) begin
        grant_found = 1'b1;
        grant_id    = region_id_t'(cand);
      end
    end
  end

  assign m_meta.valid = grant_found;
  assign m_meta.data  = req_data[grant_id*DATA_BITS +: DATA_BITS];
  assign m_meta.id    = grant_id;

  always_comb begin
    req_ready           = '0;
    req_ready[grant_id] = grant_found && m_meta.ready;
  end

  // Start so that region 0 wins the first round
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ptr_q <= region_id_t'(`N_REGIONS - 1);
    end else if (m_meta.valid && m_meta.ready) begin
      ptr_q <= grant_id;
    end
  end

  // A stalled request stays offered until it is taken
  a_valid_held: assert property (@(posedge aclk) disable iff (!aresetn)
    m_meta.valid && !m_meta.ready |=> m_meta.valid);

endmodule

`default_nettype wire

//--- src/tcp_port_table_ram.sv
// ######################################
// Hash slot RAM, one shared port.
// Read data appears one cycle after the
// address; a write returns the old entry.
// ######################################

`timescale 1ns/1ps
`default_nettype none

`include "tcp_conn_params.svh"

module tcp_port_table_ram (
  input  logic                aclk,
  input  logic                we,
  input  tcp_conn_pkg::hash_t addr,
  input  tcp_conn_pkg::slot_t wdata,
  output tcp_conn_pkg::slot_t rdata
);
  import tcp_conn_pkg::*;

  slot_t mem [2**`HASH_BITS];

  always_ff @(posedge aclk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

//--- src/tcp_conn_table.sv
// ######################################
// Connection table FSM. Claims a hash slot
// for each open request, answers collisions
// and routes stack responses to the owner.
// One table transaction at a time.
// ######################################

`timescale 1ns/1ps
`default_nettype none

`include "tcp_conn_params.svh"

module tcp_conn_table (
  input  logic                   aclk,
  input  logic                   aresetn,
  meta_if.s                      s_open,
  meta_if.m                      m_open,
  input  logic                   stack_rsp_valid,
  output logic                   stack_rsp_ready,
  input  tcp_conn_pkg::ip_addr_t stack_rsp_addr,
  input  tcp_conn_pkg::ip_port_t stack_rsp_port,
  input  tcp_conn_pkg::tcp_sid_t stack_rsp_sid,
  input  logic                   stack_rsp_success,
  output logic [`N_REGIONS-1:0]  rsp_valid,
  input  logic [`N_REGIONS-1:0]  rsp_ready,
  output tcp_conn_pkg::ip_addr_t rsp_addr,
  output tcp_conn_pkg::ip_port_t rsp_port,
  output tcp_conn_pkg::tcp_sid_t rsp_sid,
  output logic                   rsp_success
);
  import tcp_conn_pkg::*;

  localparam int KEY_BITS = `IP_ADDR_BITS + `IP_PORT_BITS;

  conn_state_t state_q, state_d;
  ip_addr_t    addr_q;
  ip_port_t    port_q;
  tcp_sid_t    sid_q;
  logic        success_q;
  region_id_t  region_q;
  hash_t       hash_q;
  logic        lup_wait;
  hash_t       sweep_cnt;
  logic        sweep_done;

  logic        ram_we;
  hash_t       ram_addr;
  slot_t       ram_wdata;
  slot_t       ram_rdata;
  logic        slot_held;
  logic        open_fire;
  logic        rsp_in_fire;
  logic        rsp_out_fire;

  // XOR of all key bytes
  function automatic hash_t fold_key(ip_addr_t a, ip_port_t p);
    logic [KEY_BITS-1:0] key;
    hash_t               h;
    key = {a, p};
    h   = '0;
    for (int i = 0; i < KEY_BITS / `HASH_BITS; i++) begin
      h ^= key[i*`HASH_BITS +: `HASH_BITS];
    end
    return h;
  endfunction

  assign slot_held = ram_rdata[`REGION_BITS];

  // Stack responses take priority over new requests
  assign stack_rsp_ready = (state_q == IDLE) && sweep_done;
  assign s_open.ready    = (state_q == IDLE) && sweep_done && !stack_rsp_valid;

  assign open_fire    = s_open.valid && s_open.ready;
  assign rsp_in_fire  = stack_rsp_valid && stack_rsp_ready;
  assign rsp_out_fire = |(rsp_valid & rsp_ready);

  assign m_open.valid = (state_q == REQ_SEND);
  assign m_open.data  = {addr_q, port_q};
  assign m_open.id    = region_q;

  always_comb begin
    rsp_valid = '0;
    if (state_q == REQ_COL || state_q == RSP_SEND) begin
      rsp_valid[region_q] = 1'b1;
    end
  end

  assign rsp_addr    = addr_q;
  assign rsp_port    = port_q;
  assign rsp_sid     = sid_q;
  assign rsp_success = success_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (rsp_in_fire) begin
          state_d = RSP_HASH;
        end else if (open_fire) begin
          state_d = REQ_HASH;
        end
      end
      REQ_HASH:  state_d = REQ_LUP;
      REQ_LUP:   state_d = REQ_CHECK;
      REQ_CHECK: state_d = slot_held ? REQ_COL : REQ_SEND;
      REQ_SEND:  state_d = m_open.ready ? IDLE : REQ_SEND;
      REQ_COL:   state_d = rsp_ready[region_q] ? IDLE : REQ_COL;
      RSP_HASH:  state_d = RSP_LUP;
      RSP_LUP:   state_d = lup_wait ? RSP_SEND : RSP_LUP;
      RSP_SEND:  state_d = rsp_ready[region_q] ? IDLE : RSP_SEND;
      default:   state_d = IDLE;
    endcase
  end

  // Sweep clears every slot after reset, then the FSM owns the port
  always_comb begin
    ram_we    = 1'b0;
    ram_addr  = hash_q;
    ram_wdata = {1'b1, region_q};
    if (!sweep_done) begin
      ram_we    = 1'b1;
      ram_addr  = sweep_cnt;
      ram_wdata = '0;
    end else if (state_q == REQ_CHECK && !slot_held) begin
      ram_we = 1'b1;
    end else if (state_q == RSP_SEND && rsp_out_fire && !success_q) begin
      ram_we    = 1'b1;
      ram_wdata = '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q    <= IDLE;
      lup_wait   <= 1'b0;
      sweep_cnt  <= '0;
      sweep_done <= 1'b0;
    end else begin
      state_q  <= state_d;
      lup_wait <= (state_q == RSP_LUP) && !lup_wait;
      if (!sweep_done) begin
        sweep_cnt <= sweep_cnt + 1'b1;
        if (sweep_cnt == '1) begin
          sweep_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rsp_in_fire) begin
      addr_q    <= stack_rsp_addr;
      port_q    <= stack_rsp_port;
      sid_q     <= stack_rsp_sid;
      success_q <= stack_rsp_success;
    end else if (open_fire) begin
      {addr_q, port_q} <= s_open.data;
      region_q         <= s_open.id;
      // A collision answer carries sid 0 and no success
      sid_q            <= '0;
      success_q        <= 1'b0;
    end
    if (state_q == REQ_HASH || state_q == RSP_HASH) begin
      hash_q <= fold_key(addr_q, port_q);
    end
    // Second lookup cycle takes the owner into the routing register
    if (state_q == RSP_LUP && lup_wait) begin
      region_q <= ram_rdata[`REGION_BITS-1:0];
    end
  end

  tcp_port_table_ram i_port_table_ram (
    .aclk  (aclk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  a_open_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_open.valid && !m_open.ready |=> m_open.valid && $stable(m_open.data));

  a_rsp_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(rsp_valid));

  // A request waiting at the stack owns its slot in the RAM
  a_send_claimed: assert property (@(posedge aclk) disable iff (!aresetn)
    m_open.valid && $past(m_open.valid) |-> ram_rdata == {1'b1, region_q});

endmodule

`default_nettype wire

//--- src/tcp_conn_top.sv
// ######################################
// Top level of the TCP connection table.
// Region lanes are flattened, region i in
// bits [i*W +: W]; the stack side is one
// plain valid/ready channel per direction.
// ######################################

`timescale 1ns/1ps
`default_nettype none

`include "tcp_conn_params.svh"

module tcp_conn_top (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic [`N_REGIONS-1:0]               open_req_valid,
  output logic [`N_REGIONS-1:0]               open_req_ready,
  input  logic [`N_REGIONS*`IP_ADDR_BITS-1:0] open_req_addr,
  input  logic [`N_REGIONS*`IP_PORT_BITS-1:0] open_req_port,
  input  logic [`N_REGIONS-1:0]               close_req_valid,
  output logic [`N_REGIONS-1:0]               close_req_ready,
  input  logic [`N_REGIONS*`SID_BITS-1:0]     close_req_sid,
  output logic [`N_REGIONS-1:0]               open_rsp_valid,
  input  logic [`N_REGIONS-1:0]               open_rsp_ready,
  output logic [`IP_ADDR_BITS-1:0]            open_rsp_addr,
  output logic [`IP_PORT_BITS-1:0]            open_rsp_port,
  output logic [`SID_BITS-1:0]                open_rsp_sid,
  output logic                                open_rsp_success,
  output logic                                stack_open_valid,
  input  logic                                stack_open_ready,
  output logic [`IP_ADDR_BITS-1:0]            stack_open_addr,
  output logic [`IP_PORT_BITS-1:0]            stack_open_port,
  output logic                                stack_close_valid,
  input  logic                                stack_close_ready,
  output logic [`SID_BITS-1:0]                stack_close_sid,
  input  logic                                stack_rsp_valid,
  output logic                                stack_rsp_ready,
  input  logic [`IP_ADDR_BITS-1:0]            stack_rsp_addr,
  input  logic [`IP_PORT_BITS-1:0]            stack_rsp_port,
  input  logic [`SID_BITS-1:0]                stack_rsp_sid,
  input  logic                                stack_rsp_success
);

  localparam int OPEN_BITS = `IP_ADDR_BITS + `IP_PORT_BITS;

  logic [`N_REGIONS*OPEN_BITS-1:0] open_req_data;

  meta_if #(.DATA_BITS(OPEN_BITS)) open_arb ();
  meta_if #(.DATA_BITS(OPEN_BITS)) open_out ();
  meta_if #(.DATA_BITS(`SID_BITS)) close_arb ();

  // Address above port in each lane
  for (genvar i = 0; i < `N_REGIONS; i++) begin : g_open_lane
    assign open_req_data[i*OPEN_BITS +: OPEN_BITS] =
      {open_req_addr[i*`IP_ADDR_BITS +: `IP_ADDR_BITS],
       open_req_port[i*`IP_PORT_BITS +: `IP_PORT_BITS]};
  end

  meta_arbiter #(.DATA_BITS(OPEN_BITS)) i_open_arbiter (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (open_req_valid),
    .req_ready (open_req_ready),
    .req_data  (open_req_data),
    .m_meta    (open_arb)
  );

  // Close path bypasses the table
  meta_arbiter #(.DATA_BITS(`SID_BITS)) i_close_arbiter (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (close_req_valid),
    .req_ready (close_req_ready),
    .req_data  (close_req_sid),
    .m_meta    (close_arb)
  );

  assign stack_close_valid = close_arb.valid;
  assign stack_close_sid   = close_arb.data;
  assign close_arb.ready   = stack_close_ready;

  tcp_conn_table i_conn_table (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .s_open            (open_arb),
    .m_open            (open_out),
    .stack_rsp_valid   (stack_rsp_valid),
    .stack_rsp_ready   (stack_rsp_ready),
    .stack_rsp_addr    (stack_rsp_addr),
    .stack_rsp_port    (stack_rsp_port),
    .stack_rsp_sid     (stack_rsp_sid),
    .stack_rsp_success (stack_rsp_success),
    .rsp_valid         (open_rsp_valid),
    .rsp_ready         (open_rsp_ready),
    .rsp_addr          (open_rsp_addr),
    .rsp_port          (open_rsp_port),
    .rsp_sid           (open_rsp_sid),
    .rsp_success       (open_rsp_success)
  );

  assign stack_open_valid                  = open_out.valid;
  assign {stack_open_addr, stack_open_port} = open_out.data;
  assign open_out.ready                    = stack_open_ready;

endmodule

`default_nettype wire

//--- bench/tcp_conn_tb.sv
// ######################################
// Self-checking testbench for the TCP
// connection table. Plays all regions and
// the stack from the testdata file and
// checks against a model of held slots.
// Run from the project root.
// ######################################

`timescale 1ns/1ps
`default_nettype none

`include "tcp_conn_params.svh"

module tcp_conn_tb;

  localparam int NR      = `N_REGIONS;
  localparam int AW      = `IP_ADDR_BITS;
  localparam int PW      = `IP_PORT_BITS;
  localparam int SW      = `SID_BITS;
  localparam int TIMEOUT = 2000;

  logic              aclk;
  logic              aresetn;
  logic [NR-1:0]     open_req_valid;
  logic [NR-1:0]     open_req_ready;
  logic [NR*AW-1:0]  open_req_addr;
  logic [NR*PW-1:0]  open_req_port;
  logic [NR-1:0]     close_req_valid;
  logic [NR-1:0]     close_req_ready;
  logic [NR*SW-1:0]  close_req_sid;
  logic [NR-1:0]     open_rsp_valid;
  logic [NR-1:0]     open_rsp_ready;
  logic [AW-1:0]     open_rsp_addr;
  logic [PW-1:0]     open_rsp_port;
  logic [SW-1:0]     open_rsp_sid;
  logic              open_rsp_success;
  logic              stack_open_valid;
  logic              stack_open_ready;
  logic [AW-1:0]     stack_open_addr;
  logic [PW-1:0]     stack_open_port;
  logic              stack_close_valid;
  logic              stack_close_ready;
  logic [SW-1:0]     stack_close_sid;
  logic              stack_rsp_valid;
  logic              stack_rsp_ready;
  logic [AW-1:0]     stack_rsp_addr;
  logic [PW-1:0]     stack_rsp_port;
  logic [SW-1:0]     stack_rsp_sid;
  logic              stack_rsp_success;

  // Values applied on the next rising edge
  logic [NR-1:0]     open_valid_nx;
  logic [NR*AW-1:0]  open_addr_nx;
  logic [NR*PW-1:0]  open_port_nx;
  logic [NR-1:0]     close_valid_nx;
  logic [NR*SW-1:0]  close_sid_nx;
  logic              rsp_valid_nx;
  logic [AW-1:0]     rsp_addr_nx;
  logic [PW-1:0]     rsp_port_nx;
  logic [SW-1:0]     rsp_sid_nx;
  logic              rsp_success_nx;

  // Table model and outstanding work
  logic              held [256];
  logic [1:0]        owner [256];
  logic [1:0]        rr_open;
  logic [1:0]        rr_close;
  logic [1:0]        out_region [$];
  logic              out_fwd [$];
  logic [AW+PW-1:0]  out_key [$];
  int                open_left;
  int                close_left;
  int                rsp_left;
  logic              rsp_routing;
  logic [1:0]        rsp_exp;
  logic              open_first_chk;
  logic              close_first_chk;
  logic [1:0]        open_first;
  logic [1:0]        close_first;
  logic [31:0]       lfsr;

  tcp_conn_top i_tcp_conn_top (.*);

  always #10 aclk = ~aclk;

  task automatic report_failure(input string text);
    $display("%s", text);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else
      report_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // XOR of the six key bytes
  function automatic logic [7:0] key_hash(input logic [AW+PW-1:0] key);
    return key[47:40] ^ key[39:32] ^ key[31:24] ^ key[23:16] ^ key[15:8] ^ key[7:0];
  endfunction

  function automatic logic [1:0] rr_pick(input logic [NR-1:0] valid,
                                         input logic [1:0] last);
    logic [1:0] idx;
    idx = last;
    for (int k = 0; k < NR; k++) begin
      idx = idx + 2'd1;
      if (valid[idx]) begin
        return idx;
      end
    end
    return last;
  endfunction

  function automatic logic next_rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  task automatic load_line(input logic [7:0] op, input logic [3:0] mask,
                           input logic [31:0] addr, input logic [15:0] port,
                           input logic [15:0] sid, input logic success,
                           input logic [1:0] region);
    case (op[3:0])
      4'h1: begin
        // Region i opens address + i
        for (int i = 0; i < NR; i++) begin
          if (mask[i]) begin
            open_valid_nx[i]          = 1'b1;
            open_addr_nx[i*AW +: AW]  = addr + i;
            open_port_nx[i*PW +: PW]  = port;
          end
        end
        open_left      += $countones(mask);
        open_first_chk  = 1'b1;
        open_first      = region;
      end
      4'h2: begin
        rsp_valid_nx   = 1'b1;
        rsp_addr_nx    = addr;
        rsp_port_nx    = port;
        rsp_sid_nx     = sid;
        rsp_success_nx = success;
        rsp_exp        = region;
        rsp_left       = 1;
      end
      4'h3: begin
        for (int i = 0; i < NR; i++) begin
          if (mask[i]) begin
            close_valid_nx[i]         = 1'b1;
            close_sid_nx[i*SW +: SW]  = sid + i;
          end
        end
        close_left      += $countones(mask);
        close_first_chk  = 1'b1;
        close_first      = region;
      end
      default: report_failure("unknown operation in the stimulus file");
    endcase
  endtask

  // One clock cycle: sample transfers before the edge, then drive on it
  task automatic step();
    logic [1:0]       exp_r;
    logic [AW+PW-1:0] key;
    logic [7:0]       h;
    logic [NR-1:0]    rdy;
    logic             open_rdy;
    logic             close_rdy;
    @(negedge aclk);
    for (int i = 0; i < NR; i++) begin
      if (open_req_valid[i] && open_req_ready[i]) begin
        exp_r = rr_pick(open_req_valid, rr_open);
        check_value("open_req_ready lane", i, exp_r);
        if (open_first_chk) begin
          check_value("open_req_ready first lane", i, open_first);
          open_first_chk = 1'b0;
        end
        rr_open          = 2'(i);
        open_valid_nx[i] = 1'b0;
        key              = {open_req_addr[i*AW +: AW], open_req_port[i*PW +: PW]};
        h                = key_hash(key);
        out_region.push_back(2'(i));
        out_key.push_back(key);
        out_fwd.push_back(!held[h]);
        if (!held[h]) begin
          held[h]  = 1'b1;
          owner[h] = 2'(i);
        end
      end
    end
    for (int i = 0; i < NR; i++) begin
      if (close_req_valid[i] && close_req_ready[i]) begin
        exp_r = rr_pick(close_req_valid, rr_close);
        check_value("close_req_ready lane", i, exp_r);
        if (close_first_chk) begin
          check_value("close_req_ready first lane", i, close_first);
          close_first_chk = 1'b0;
        end
        assert (stack_close_valid && stack_close_ready) else
          report_failure("close request accepted without a transfer to the stack");
        check_value("stack_close_sid", stack_close_sid, close_req_sid[i*SW +: SW]);
        rr_close          = 2'(i);
        close_valid_nx[i] = 1'b0;
        close_left--;
      end
    end
    assert (!(stack_close_valid && stack_close_ready) || |(close_req_valid & close_req_ready))
      else report_failure("stack close transfer with no close request accepted");
    if (stack_open_valid && stack_open_ready) begin
      assert (out_fwd.size() > 0) else
        report_failure("request reached the stack with no open request pending");
      assert (out_fwd[0]) else
        report_failure("request reached the stack although its slot is held");
      check_value("stack_open_addr", stack_open_addr, out_key[0][AW+PW-1:PW]);
      check_value("stack_open_port", stack_open_port, out_key[0][PW-1:0]);
      void'(out_region.pop_front());
      void'(out_key.pop_front());
      void'(out_fwd.pop_front());
      open_left--;
    end
    if (|(open_rsp_valid & open_rsp_ready)) begin
      if (rsp_routing) begin
        check_value("open_rsp_valid", open_rsp_valid, 4'b0001 << rsp_exp);
        check_value("open_rsp_addr", open_rsp_addr, rsp_addr_nx);
        check_value("open_rsp_port", open_rsp_port, rsp_port_nx);
        check_value("open_rsp_sid", open_rsp_sid, rsp_sid_nx);
        check_value("open_rsp_success", open_rsp_success, rsp_success_nx);
        if (!rsp_success_nx) begin
          held[key_hash({rsp_addr_nx, rsp_port_nx})] = 1'b0;
        end
        rsp_routing = 1'b0;
        rsp_left    = 0;
      end else begin
        assert (out_fwd.size() > 0) else
          report_failure("region response with no request or stack response pending");
        assert (!out_fwd[0]) else
          report_failure("collision response for a request to a free slot");
        check_value("open_rsp_valid", open_rsp_valid, 4'b0001 << out_region[0]);
        check_value("open_rsp_addr", open_rsp_addr, out_key[0][AW+PW-1:PW]);
        check_value("open_rsp_port", open_rsp_port, out_key[0][PW-1:0]);
        check_value("open_rsp_sid", open_rsp_sid, 0);
        check_value("open_rsp_success", open_rsp_success, 0);
        void'(out_region.pop_front());
        void'(out_key.pop_front());
        void'(out_fwd.pop_front());
        open_left--;
      end
    end
    if (stack_rsp_valid && stack_rsp_ready) begin
      h = key_hash({stack_rsp_addr, stack_rsp_port});
      assert (held[h] && owner[h] == rsp_exp) else
        report_failure("stack response in the stimulus file hits no slot of that region");
      rsp_valid_nx = 1'b0;
      rsp_routing  = 1'b1;
    end
    // Random back-pressure on every ready input
    for (int i = 0; i < NR; i++) begin
      rdy[i] = next_rand_bit();
    end
    open_rdy  = next_rand_bit();
    close_rdy = next_rand_bit();
    @(posedge aclk);
    open_rsp_ready    <= rdy;
    stack_open_ready  <= open_rdy;
    stack_close_ready <= close_rdy;
    open_req_valid    <= open_valid_nx;
    open_req_addr     <= open_addr_nx;
    open_req_port     <= open_port_nx;
    close_req_valid   <= close_valid_nx;
    close_req_sid     <= close_sid_nx;
    stack_rsp_valid   <= rsp_valid_nx;
    stack_rsp_addr    <= rsp_addr_nx;
    stack_rsp_port    <= rsp_port_nx;
    stack_rsp_sid     <= rsp_sid_nx;
    stack_rsp_success <= rsp_success_nx;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (open_left > 0 || close_left > 0 || rsp_left > 0) begin
      step();
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("timeout waiting for outstanding transfers to complete");
      end
    end
  endtask

  initial begin : main
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [3:0]  mask;
    logic [31:0] addr;
    logic [15:0] port;
    logic [15:0] sid;
    logic        success;
    logic [1:0]  region;
    aclk = 1'b0;
    aresetn = 1'b0;
    {open_req_valid, open_req_addr, open_req_port, open_rsp_ready} = '0;
    {close_req_valid, close_req_sid, stack_open_ready, stack_close_ready} = '0;
    {stack_rsp_valid, stack_rsp_addr, stack_rsp_port, stack_rsp_sid, stack_rsp_success} = '0;
    {open_valid_nx, open_addr_nx, open_port_nx, close_valid_nx, close_sid_nx} = '0;
    {rsp_valid_nx, rsp_addr_nx, rsp_port_nx, rsp_sid_nx, rsp_success_nx} = '0;
    for (int k = 0; k < 256; k++) begin
      held[k]  = 1'b0;
      owner[k] = '0;
    end
    // Region 0 is served first after reset
    rr_open = 2'd3;
    rr_close = 2'd3;
    {open_left, close_left, rsp_left} = '0;
    {rsp_routing, rsp_exp, open_first_chk, close_first_chk, open_first, close_first} = '0;
    lfsr = 32'ha638_5bb3;
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
    fd = $fopen("bench/tcp_conn_testdata.txt", "r");
    assert (fd != 0) else report_failure("cannot open the stimulus file");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", op, mask, addr, port, sid, success, region);
        assert (n == 7) else report_failure("malformed line in the stimulus file");
        load_line(op, mask, addr, port, sid, success, region);
        // High digit set posts the line without waiting
        if (op[7:4] == 4'h0) begin
          wait_idle();
        end
      end
    end
    $fclose(fd);
    wait_idle();
    // Quiet cycles catch any stray transfer
    repeat (20) step();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/tcp_conn_pkg.sv
src/meta_if.sv
src/meta_arbiter.sv
src/tcp_port_table_ram.sv
src/tcp_conn_table.sv
src/tcp_conn_top.sv
bench/tcp_conn_tb.sv

//--- Bender.yml
package:
  name: tcp_conn_table

sources:
  - include_dirs:
      - src
    files:
      - src/tcp_conn_pkg.sv
      - src/meta_if.sv
      - src/meta_arbiter.sv
      - src/tcp_port_table_ram.sv
      - src/tcp_conn_table.sv
      - src/tcp_conn_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tcp_conn_tb.sv

//--- bench/tcp_conn_testdata.txt
# op mask addr port sid success region, all hex; region is the first grant or the owner
# op 1 open (region i uses addr+i), 2 stack response, 3 close (region i uses sid+i)
# op 11 posts an open and moves on without waiting for it
01 1 0a000001 1f90 0000 0 0
01 2 01000a00 901f 0000 0 1
02 0 0a000001 1f90 0101 0 0
01 4 09ffffff 1f90 0000 0 2
02 0 0a000001 1f90 0202 1 2
01 1 0a000001 1f90 0000 0 0
01 f c0a80010 0050 0000 0 1
02 0 c0a80012 0050 0033 1 2
02 0 c0a80011 0050 0034 0 1
03 f 00000000 0000 1000 0 0
11 5 ac100000 0016 0000 0 2
03 a 00000000 0000 2000 0 1
01 8 00000000 0000 0000 0 3
02 0 00000003 0000 ffff 1 3
01 2 c0a80010 0050 0000 0 1
01 8 c0a8000f 0050 0000 0 3
03 6 00000000 0000 3000 0 1
